// File: Bender.yml
package:
  name: stepper_core

sources:
  - hdl/stepper_pkg.sv
  - hdl/wb_bus_if.sv
  - hdl/command_parser.sv
  - hdl/move_bus_arbiter.sv
  - hdl/move_buffer.sv
  - hdl/dda_step_timer.sv
  - hdl/stepper_core.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_stepper_core.sv

// File: all.f
hdl/stepper_pkg.sv
hdl/wb_bus_if.sv
hdl/command_parser.sv
hdl/move_bus_arbiter.sv
hdl/move_buffer.sv
hdl/dda_step_timer.sv
hdl/stepper_core.sv
testbench/tb_clock_gen.sv
testbench/tb_stepper_core.sv

// File: hdl/command_parser.sv
`default_nettype none

module command_parser #(
  parameter int MOVE_SLOTS = 4
) (
  input  wire                             CLK,
  input  wire                             resetn,
  input  wire                             word_valid,
  input  wire  [stepper_pkg::WORD_W-1:0]  word_data,
  output logic                            word_ready,
  output logic [stepper_pkg::WORD_W-1:0]  reply_data,
  output logic                            enable,
  output logic [7:0]                      clock_divisor,
  output logic [MOVE_SLOTS-1:0]           slot_ready,
  input  wire  [MOVE_SLOTS-1:0]           slot_done,
  output logic                            buffer_ready,
  wb_bus_if.master                        bus
);

  localparam int SLOT_W = $clog2(MOVE_SLOTS);
  localparam int W = stepper_pkg::WORD_W;

  typedef enum logic [1:0] {
    IDLE_HEADER,
    MOVE_BODY,
    VERSION_BODY,
    WRITE_WAIT
  } state_e;

  state_e              state;
  stepper_pkg::field_e cur_field;
  logic [SLOT_W-1:0]   wr_idx;
  logic                wr_cyc;
  logic [W-1:0]        wr_data;
  logic [7:0]          header;
  logic                slot_busy;
  logic                hdr_blocked;
  logic                accept;

  // Opcode sits in the top byte
  assign header = word_data[W-1 -: 8];

  // Slot at the write index still holds a move the timer has not finished
  assign slot_busy = slot_ready[wr_idx] ^ slot_done[wr_idx];
  assign buffer_ready = ~&(slot_ready ^ slot_done);

  // Back-pressure on a step header until its slot is free
  assign hdr_blocked = (state == IDLE_HEADER) && word_valid && slot_busy &&
                       (header == stepper_pkg::CMD_COORDINATED_STEP);
  assign word_ready = (state != WRITE_WAIT) && !hdr_blocked;
  assign accept = word_valid && word_ready;

  // Record write towards the arbiter
  assign bus.cyc = wr_cyc;
  assign bus.stb = wr_cyc;
  assign bus.we = 1'b1;
  assign bus.adr = {wr_idx, cur_field};
  assign bus.dat_w = wr_data;

  // Header carries the direction in bit 0, body words go out whole
  always_ff @(posedge CLK) begin
    if (accept) begin
      if (state == IDLE_HEADER) begin
        wr_data <= {{(W-1){1'b0}}, word_data[0]};
      end else begin
        wr_data <= word_data;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state <= IDLE_HEADER;
      cur_field <= stepper_pkg::FIELD_DIR;
      wr_idx <= '0;
      wr_cyc <= 1'b0;
      slot_ready <= '0;
      enable <= 1'b0;
      clock_divisor <= stepper_pkg::DIVISOR_RESET;
      reply_data <= '0;
    end else begin
      // Reply lives until the next accepted word
      if (accept) begin
        reply_data <= '0;
      end
      case (state)
        IDLE_HEADER: begin
          if (accept) begin
            case (header)
              stepper_pkg::CMD_COORDINATED_STEP: begin
                cur_field <= stepper_pkg::FIELD_DIR;
                wr_cyc <= 1'b1;
                state <= WRITE_WAIT;
              end
              stepper_pkg::CMD_MOTOR_ENABLE: begin
                enable <= word_data[0];
              end
              stepper_pkg::CMD_CLK_DIVISOR: begin
                clock_divisor <= word_data[7:0];
              end
              stepper_pkg::CMD_API_VERSION: begin
                // Patch, minor, major from byte 0 upwards
                reply_data <= {{(W-24){1'b0}}, stepper_pkg::VERSION_MAJOR,
                               stepper_pkg::VERSION_MINOR, stepper_pkg::VERSION_PATCH};
                state <= VERSION_BODY;
              end
              default: begin
                // Unknown opcode, word dropped
              end
            endcase
          end
        end
        MOVE_BODY: begin
          // Duration, increment, incinc in that order
          if (accept) begin
            cur_field <= stepper_pkg::field_e'(cur_field + 2'd1);
            wr_cyc <= 1'b1;
            state <= WRITE_WAIT;
          end
        end
        VERSION_BODY: begin
          // Dummy word while the version goes back
          if (accept) begin
            state <= IDLE_HEADER;
          end
        end
        WRITE_WAIT: begin
          if (bus.ack) begin
            wr_cyc <= 1'b0;
            if (cur_field == stepper_pkg::FIELD_INCINC) begin
              // Record complete, hand slot to the timer
              slot_ready[wr_idx] <= ~slot_ready[wr_idx];
              wr_idx <= wr_idx + 1'b1;
              state <= IDLE_HEADER;
            end else begin
              state <= MOVE_BODY;
            end
          end
        end
        default: begin
          state <= IDLE_HEADER;
        end
      endcase
    end
  end

  // Timer must never claim the slot while its record is being written
  a_write_free_slot: assert property (@(posedge CLK) disable iff (!resetn)
    wr_cyc |-> !slot_busy);

endmodule

`default_nettype wire

// File: hdl/dda_step_timer.sv
`default_nettype none

module dda_step_timer #(
  parameter int MOVE_SLOTS = 4
) (
  input  wire                   CLK,
  input  wire                   resetn,
  input  wire  [7:0]            clock_divisor,
  input  wire                   halt,
  input  wire  [MOVE_SLOTS-1:0] slot_ready,
  output logic [MOVE_SLOTS-1:0] slot_done,
  output logic                  step,
  output logic                  dir,
  output logic                  move_done,
  wb_bus_if.master              bus
);

  localparam int SLOT_W = $clog2(MOVE_SLOTS);
  localparam int W = stepper_pkg::WORD_W;
  localparam logic [W-1:0] ONE = 1;

  typedef enum logic [1:0] {
    WAIT_MOVE,
    FETCH,
    RUN
  } state_e;

  state_e              state;
  stepper_pkg::field_e rd_field;
  logic [SLOT_W-1:0]   rd_idx;
  logic                rd_cyc;
  logic [7:0]          presc;
  logic                tick;
  logic                last_tick;
  logic                pending;
  logic [W-1:0]        ticks_left;
  logic [W-1:0]        increment;
  logic [W-1:0]        incinc;
  logic [W-1:0]        phase;
  logic [W:0]          phase_sum;

  // Toggle bits differ while the parser has a move queued here
  assign pending = slot_ready[rd_idx] ^ slot_done[rd_idx];

  // Read-only master
  assign bus.cyc = rd_cyc;
  assign bus.stb = rd_cyc;
  assign bus.we = 1'b0;
  assign bus.adr = {rd_idx, rd_field};
  assign bus.dat_w = '0;

  // Prescaled tick, frozen by halt
  assign tick = (state == RUN) && !halt && (presc >= clock_divisor - 8'd1);
  // Carry out of bit 63 is a step
  assign phase_sum = {1'b0, phase} + {1'b0, increment};
  assign last_tick = (ticks_left <= ONE);

  // DDA datapath
  always_ff @(posedge CLK) begin
    if (state == WAIT_MOVE) begin
      phase <= '0;
    end else if (tick) begin
      phase <= phase_sum[W-1:0];
    end
    if (state == FETCH && bus.ack) begin
      case (rd_field)
        stepper_pkg::FIELD_DURATION:  ticks_left <= bus.dat_r;
        stepper_pkg::FIELD_INCREMENT: increment <= bus.dat_r;
        stepper_pkg::FIELD_INCINC:    incinc <= bus.dat_r;
        default:                      ticks_left <= ticks_left;
      endcase
    end else if (tick) begin
      ticks_left <= ticks_left - ONE;
      // Acceleration term
      increment <= increment + incinc;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state <= WAIT_MOVE;
      rd_field <= stepper_pkg::FIELD_DIR;
      rd_idx <= '0;
      rd_cyc <= 1'b0;
      presc <= '0;
      slot_done <= '0;
      step <= 1'b0;
      dir <= 1'b0;
      move_done <= 1'b0;
    end else begin
      step <= tick && phase_sum[W];
      move_done <= 1'b0;
      case (state)
        WAIT_MOVE: begin
          if (pending) begin
            rd_field <= stepper_pkg::FIELD_DIR;
            rd_cyc <= 1'b1;
            state <= FETCH;
          end
        end
        FETCH: begin
          // One read per bus cycle, cyc drops between fields
          if (bus.ack) begin
            rd_cyc <= 1'b0;
            if (rd_field == stepper_pkg::FIELD_DIR) begin
              dir <= bus.dat_r[0];
            end
            if (rd_field == stepper_pkg::FIELD_INCINC) begin
              presc <= '0;
              state <= RUN;
            end else begin
              rd_field <= stepper_pkg::field_e'(rd_field + 2'd1);
            end
          end else if (!rd_cyc) begin
            rd_cyc <= 1'b1;
          end
        end
        RUN: begin
          if (tick) begin
            presc <= '0;
          end else if (!halt) begin
            presc <= presc + 8'd1;
          end
          // Duration used up, release slot and look at the next
          if (tick && last_tick) begin
            move_done <= 1'b1;
            slot_done[rd_idx] <= ~slot_done[rd_idx];
            rd_idx <= rd_idx + 1'b1;
            state <= WAIT_MOVE;
          end
        end
        default: begin
          state <= WAIT_MOVE;
        end
      endcase
    end
  end

  // Step shows while running, or with the move_done that ends the move
  a_step_in_run: assert property (@(posedge CLK) disable iff (!resetn)
    step |-> (state == RUN) || (state == WAIT_MOVE && move_done));

endmodule

`default_nettype wire

// File: hdl/move_buffer.sv
`default_nettype none

module move_buffer #(
  parameter int MOVE_SLOTS = 4
) (
  input  wire      CLK,
  input  wire      resetn,
  wb_bus_if.slave  bus
);

  // Four words per move record
  localparam int DEPTH = MOVE_SLOTS * 4;
  localparam int W = stepper_pkg::WORD_W;

  logic [W-1:0] mem [DEPTH];
  logic [W-1:0] rd_data;
  logic         ack_q;
  logic         req;

  // New request only while no ack is outstanding
  assign req = bus.cyc && bus.stb && !ack_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // Single port, write or read per request
  always_ff @(posedge CLK) begin
    if (req) begin
      if (bus.we) begin
        mem[bus.adr] <= bus.dat_w;
      end
      rd_data <= mem[bus.adr];
    end
  end

  assign bus.ack = ack_q;
  assign bus.dat_r = rd_data;

  // Masters drop cyc after ack, so ack is a single pulse
  a_ack_pulse: assert property (@(posedge CLK) disable iff (!resetn)
    bus.ack |=> !bus.ack);

endmodule

`default_nettype wire

// File: hdl/move_bus_arbiter.sv
`default_nettype none

module move_bus_arbiter (
  input  wire       CLK,
  input  wire       resetn,
  wb_bus_if.slave   m0,
  wb_bus_if.slave   m1,
  wb_bus_if.master  mem
);

  // grant 0 is the parser, 1 the step timer
  logic busy;
  logic grant;
  logic owner_cyc;

  assign owner_cyc = grant ? m1.cyc : m0.cyc;

  // Rearbitrate only once the owner has let go
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy <= 1'b0;
      grant <= 1'b0;
    end else if (!busy || !owner_cyc) begin
      if (m0.cyc) begin
        busy <= 1'b1;
        grant <= 1'b0;
      end else if (m1.cyc) begin
        busy <= 1'b1;
        grant <= 1'b1;
      end else begin
        busy <= 1'b0;
      end
    end
  end

  // Request mux
  assign mem.cyc = busy && owner_cyc;
  assign mem.stb = busy && (grant ? m1.stb : m0.stb);
  assign mem.we = grant ? m1.we : m0.we;
  assign mem.adr = grant ? m1.adr : m0.adr;
  assign mem.dat_w = grant ? m1.dat_w : m0.dat_w;

  // Read data is shared, ack goes to the owner only
  assign m0.dat_r = mem.dat_r;
  assign m1.dat_r = mem.dat_r;
  assign m0.ack = mem.ack && busy && !grant;
  assign m1.ack = mem.ack && busy && grant;

  // Owner is locked for its whole bus cycle
  a_grant_locked: assert property (@(posedge CLK) disable iff (!resetn)
    mem.cyc |=> $stable(grant));

  // Each ack answers a request the same owner made one cycle earlier
  a_ack_owner: assert property (@(posedge CLK) disable iff (!resetn)
    mem.ack |-> $past(mem.cyc && mem.stb) && $stable(grant));

endmodule

`default_nettype wire

// File: hdl/stepper_core.sv
`default_nettype none

module stepper_core #(
  parameter int MOVE_SLOTS = 4
) (
  input  wire                            CLK,
  input  wire                            resetn,
  input  wire                            word_valid,
  input  wire  [stepper_pkg::WORD_W-1:0] word_data,
  output wire                            word_ready,
  output wire  [stepper_pkg::WORD_W-1:0] reply_data,
  input  wire                            halt,
  output wire                            step,
  output wire                            dir,
  output wire                            enable,
  output wire                            move_done,
  output wire                            buffer_ready
);

  // Slot index plus field offset
  localparam int ADR_W = $clog2(MOVE_SLOTS) + 2;

  wire [7:0]            clock_divisor;
  wire [MOVE_SLOTS-1:0] slot_ready;
  wire [MOVE_SLOTS-1:0] slot_done;

  wb_bus_if #(.ADR_W(ADR_W)) parser_bus ();
  wb_bus_if #(.ADR_W(ADR_W)) dda_bus ();
  wb_bus_if #(.ADR_W(ADR_W)) mem_bus ();

  // Host side, owns config registers and the write index
  command_parser #(.MOVE_SLOTS(MOVE_SLOTS)) i_command_parser (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_ready    (word_ready),
    .reply_data    (reply_data),
    .enable        (enable),
    .clock_divisor (clock_divisor),
    .slot_ready    (slot_ready),
    .slot_done     (slot_done),
    .buffer_ready  (buffer_ready),
    .bus           (parser_bus.master)
  );

  // Step generation from queued moves
  dda_step_timer #(.MOVE_SLOTS(MOVE_SLOTS)) i_dda_step_timer (
    .CLK           (CLK),
    .resetn        (resetn),
    .clock_divisor (clock_divisor),
    .halt          (halt),
    .slot_ready    (slot_ready),
    .slot_done     (slot_done),
    .step          (step),
    .dir           (dir),
    .move_done     (move_done),
    .bus           (dda_bus.master)
  );

  // Parser on port 0 wins ties
  move_bus_arbiter i_move_bus_arbiter (
    .CLK    (CLK),
    .resetn (resetn),
    .m0     (parser_bus.slave),
    .m1     (dda_bus.slave),
    .mem    (mem_bus.master)
  );

  move_buffer #(.MOVE_SLOTS(MOVE_SLOTS)) i_move_buffer (
    .CLK    (CLK),
    .resetn (resetn),
    .bus    (mem_bus.slave)
  );

endmodule

`default_nettype wire

// File: hdl/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Host words, buffer words and DDA registers share one width
  localparam int WORD_W = 64;

  // Opcodes in bits 63..56 of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0A,
    CMD_CLK_DIVISOR      = 8'h14,
    CMD_API_VERSION      = 8'hFE
  } cmd_e;

  // Word offset of each field inside one move record
  // Record of slot s starts at buffer address s*4
  typedef enum logic [1:0] {
    FIELD_DIR       = 2'd0,
    FIELD_DURATION  = 2'd1,
    FIELD_INCREMENT = 2'd2,
    FIELD_INCINC    = 2'd3
  } field_e;

  // Reported by the API version query
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

  // Prescaler value after reset
  localparam logic [7:0] DIVISOR_RESET = 8'd40;

endpackage

`default_nettype wire

// File: hdl/wb_bus_if.sv
`default_nettype none

interface wb_bus_if #(
  parameter int ADR_W = 4
);

  // Request side, driven by the master
  logic                           cyc;
  logic                           stb;
  logic                           we;
  logic [ADR_W-1:0]               adr;
  logic [stepper_pkg::WORD_W-1:0] dat_w;

  // Response side, driven by the slave
  logic [stepper_pkg::WORD_W-1:0] dat_r;
  logic                           ack;

  modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);

  modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic resetn
);

  timeunit 1ns;
  timeprecision 100ps;

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever begin
      #20 CLK = ~CLK;
    end
  end

  // Low over the first two rising edges, released just after the second
  initial begin
    resetn = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
    resetn = 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/tb_stepper_core.sv
`default_nettype none

module tb_stepper_core;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int W = stepper_pkg::WORD_W;
  localparam int WORD_TIMEOUT = 2000;

  wire          CLK;
  wire          resetn;
  logic         word_valid;
  logic [W-1:0] word_data;
  wire          word_ready;
  wire  [W-1:0] reply_data;
  logic         halt;
  wire          step;
  wire          dir;
  wire          enable;
  wire          move_done;
  wire          buffer_ready;

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lfsr;

  // Output monitor state
  int   cycle;
  int   step_count;
  int   steps_in_move;
  int   done_count;
  int   step_cycles[$];
  int   move_steps[$];
  logic move_dirs[$];

  tb_clock_gen i_clock_gen (
    .CLK    (CLK),
    .resetn (resetn)
  );

  stepper_core #(.MOVE_SLOTS(4)) i_dut (
    .CLK          (CLK),
    .resetn       (resetn),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .word_ready   (word_ready),
    .reply_data   (reply_data),
    .halt         (halt),
    .step         (step),
    .dir          (dir),
    .enable       (enable),
    .move_done    (move_done),
    .buffer_ready (buffer_ready)
  );

  // Registered outputs sampled mid-cycle
  always @(negedge CLK) begin
    cycle = cycle + 1;
    if (step === 1'b1) begin
      step_count = step_count + 1;
      steps_in_move = steps_in_move + 1;
      step_cycles.push_back(cycle);
    end
    // Final step of a move shares its cycle with move_done
    if (move_done === 1'b1) begin
      done_count = done_count + 1;
      move_steps.push_back(steps_in_move);
      move_dirs.push_back(dir);
      steps_in_move = 0;
    end
  end

  task automatic clear_monitor();
    step_count = 0;
    steps_in_move = 0;
    done_count = 0;
    step_cycles.delete();
    move_steps.delete();
    move_dirs.delete();
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [W-1:0] random_word();
    logic [W-1:0] val;
    val = '0;
    for (int i = 0; i < W; i++) begin
      val = {val[W-2:0], lfsr_bit()};
    end
    return val;
  endfunction

  // Expected steps: phase from zero, carry out per tick, increment then grows
  function automatic int ref_steps(logic [W-1:0] inc, logic [W-1:0] incinc, int duration);
    logic [W:0]   sum;
    logic [W-1:0] phase;
    int           n;
    phase = '0;
    n = 0;
    for (int i = 0; i < duration; i++) begin
      sum = {1'b0, phase} + {1'b0, inc};
      if (sum[W])
        n++;
      phase = sum[W-1:0];
      inc = inc + incinc;
    end
    return n;
  endfunction

  task automatic report_mismatch(string name, logic [W-1:0] got, logic [W-1:0] exp);
    $display("[FAIL] %s: expected %h, got %h", name, exp, got);
    errors++;
  endtask

  task automatic report_error(string msg);
    $display("Error: %s", msg);
    errors++;
  endtask

  task automatic abort_run(string what);
    $display("Timeout: %s", what);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic finish_test(string name, int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s", name);
    end
  endtask

  task automatic wait_cycles(int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic wait_for_reset();
    int waited;
    waited = 0;
    @(negedge CLK);
    while (resetn !== 1'b1) begin
      waited++;
      if (waited > 10)
        abort_run("resetn was never released");
      @(negedge CLK);
    end
    @(posedge CLK);
    #1;
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_word(logic [W-1:0] data);
    int waited;
    waited = 0;
    word_valid = 1'b1;
    word_data = data;
    // word_ready settles well before the falling edge
    @(negedge CLK);
    while (word_ready !== 1'b1) begin
      waited++;
      if (waited > WORD_TIMEOUT)
        abort_run("word_ready stayed low");
      @(negedge CLK);
    end
    @(posedge CLK);
    #1;
    word_valid = 1'b0;
  endtask

  task automatic send_move(logic d, logic [W-1:0] dur, logic [W-1:0] inc,
                           logic [W-1:0] incinc);
    send_word({stepper_pkg::CMD_COORDINATED_STEP, 55'd0, d});
    send_word(dur);
    send_word(inc);
    send_word(incinc);
  endtask

  task automatic wait_moves_done(int n, int limit);
    int waited;
    waited = 0;
    while (done_count < n) begin
      if (waited >= limit)
        abort_run("move_done did not arrive");
      @(posedge CLK);
      #1;
      waited++;
    end
  endtask

  task automatic check_reset_and_version();
    int e0;
    e0 = errors;
    if (step !== 1'b0)
      report_mismatch("step", step, 0);
    if (move_done !== 1'b0)
      report_mismatch("move_done", move_done, 0);
    if (enable !== 1'b0)
      report_mismatch("enable", enable, 0);
    if (word_ready !== 1'b1)
      report_mismatch("word_ready", word_ready, 1);
    if (buffer_ready !== 1'b1)
      report_mismatch("buffer_ready", buffer_ready, 1);
    if (reply_data !== '0)
      report_mismatch("reply_data", reply_data, 0);
    send_word({stepper_pkg::CMD_API_VERSION, 56'd0});
    // Major 1 in byte 2, minor 2 in byte 1, patch 0 in byte 0
    if (reply_data !== 64'h0000_0000_0001_0200)
      report_mismatch("reply_data", reply_data, 64'h0000_0000_0001_0200);
    // Dummy body word clears the reply
    send_word('0);
    if (reply_data !== '0)
      report_mismatch("reply_data", reply_data, 0);
    finish_test("reset values and API version", e0);
  endtask

  task automatic check_motor_enable();
    int e0;
    e0 = errors;
    send_word({stepper_pkg::CMD_MOTOR_ENABLE, 55'd0, 1'b1});
    if (enable !== 1'b1)
      report_mismatch("enable", enable, 1);
    send_word({stepper_pkg::CMD_MOTOR_ENABLE, 55'd0, 1'b0});
    if (enable !== 1'b0)
      report_mismatch("enable", enable, 0);
    finish_test("motor enable", e0);
  endtask

  task automatic run_single_move();
    int e0;
    int gap;
    e0 = errors;
    send_word({stepper_pkg::CMD_CLK_DIVISOR, 48'd0, 8'd3});
    clear_monitor();
    // Half-turn increment, carry on every second tick
    send_move(1'b1, 64'd8, 64'h8000_0000_0000_0000, '0);
    wait_moves_done(1, 300);
    wait_cycles(10);
    if (step_count != 4)
      report_mismatch("step pulses", step_count, 4);
    if (done_count != 1)
      report_mismatch("move_done pulses", done_count, 1);
    if (dir !== 1'b1)
      report_mismatch("dir", dir, 1);
    for (int i = 1; i < step_cycles.size(); i++) begin
      gap = step_cycles[i] - step_cycles[i-1];
      // Two ticks of three cycles each
      if (gap != 6)
        report_mismatch("step spacing", gap, 6);
    end
    finish_test("single move", e0);
  endtask

  task automatic run_queued_moves();
    logic         dirs[5];
    logic [W-1:0] incs[5];
    int           expect_steps[5];
    int           waited;
    int           e0;
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      dirs[i] = lfsr_bit();
      incs[i] = random_word();
      expect_steps[i] = ref_steps(incs[i], '0, 5);
    end
    // Slow timer so the queue fills
    send_word({stepper_pkg::CMD_CLK_DIVISOR, 48'd0, 8'd100});
    clear_monitor();
    for (int i = 0; i < 4; i++) begin
      send_move(dirs[i], 64'd5, incs[i], '0);
    end
    // Last record write completes a few cycles after its word
    waited = 0;
    while (buffer_ready !== 1'b0 && waited < 20) begin
      @(posedge CLK);
      #1;
      waited++;
    end
    if (buffer_ready !== 1'b0)
      report_mismatch("buffer_ready", buffer_ready, 0);
    // Fifth header can only go in once the first move frees its slot
    send_word({stepper_pkg::CMD_COORDINATED_STEP, 55'd0, dirs[4]});
    if (done_count < 1)
      report_error("fifth header accepted while all slots were full");
    send_word(64'd5);
    send_word(incs[4]);
    send_word('0);
    wait_moves_done(5, 4000);
    if (move_steps.size() != 5) begin
      report_error("wrong number of move_done pulses for five moves");
    end else begin
      for (int i = 0; i < 5; i++) begin
        if (move_steps[i] != expect_steps[i])
          report_mismatch($sformatf("steps of move %0d", i), move_steps[i], expect_steps[i]);
        if (move_dirs[i] !== dirs[i])
          report_mismatch($sformatf("dir of move %0d", i), move_dirs[i], dirs[i]);
      end
    end
    finish_test("queued moves in order", e0);
  endtask

  task automatic run_accel_move();
    logic [W-1:0] inc;
    logic [W-1:0] incinc;
    int           expect_steps;
    int           e0;
    e0 = errors;
    inc = 64'h0200_0000_0000_0000;
    incinc = 64'h0400_0000_0000_0000;
    expect_steps = ref_steps(inc, incinc, 20);
    send_word({stepper_pkg::CMD_CLK_DIVISOR, 48'd0, 8'd2});
    clear_monitor();
    send_move(1'b0, 64'd20, inc, incinc);
    wait_moves_done(1, 300);
    if (step_count != expect_steps)
      report_mismatch("step pulses", step_count, expect_steps);
    if (dir !== 1'b0)
      report_mismatch("dir", dir, 0);
    finish_test("accelerating move", e0);
  endtask

  task automatic run_halted_move();
    int waited;
    int steps_at_halt;
    int done_at_halt;
    int e0;
    e0 = errors;
    clear_monitor();
    // Quarter-turn increment, one step per four ticks
    send_move(1'b1, 64'd16, 64'h4000_0000_0000_0000, '0);
    waited = 0;
    while (step_count < 1) begin
      if (waited >= 300)
        abort_run("no step before halt");
      @(posedge CLK);
      #1;
      waited++;
    end
    halt = 1'b1;
    // A step from the tick before halt may still show
    wait_cycles(2);
    steps_at_halt = step_count;
    done_at_halt = done_count;
    wait_cycles(40);
    if (step_count != steps_at_halt)
      report_mismatch("step pulses during halt", step_count, steps_at_halt);
    if (done_count != done_at_halt)
      report_mismatch("move_done pulses during halt", done_count, done_at_halt);
    halt = 1'b0;
    wait_moves_done(1, 300);
    if (step_count != ref_steps(64'h4000_0000_0000_0000, '0, 16))
      report_mismatch("step pulses", step_count, ref_steps(64'h4000_0000_0000_0000, '0, 16));
    finish_test("halt and resume", e0);
  endtask

  initial begin
    word_valid = 1'b0;
    word_data = '0;
    halt = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    lfsr = 32'h315a8aa4;
    wait_for_reset();
    check_reset_and_version();
    check_motor_enable();
    run_single_move();
    run_queued_moves();
    run_accel_move();
    run_halted_move();
    $display("Tests run: %0d, failed: %0d, failed checks: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
